// ==== Bender.yml ====
package:
  name: useq

export_include_dirs:
  - .

sources:
  - files:
      - useq_pkg.sv
      - insn_queue.sv
      - micro_commands.sv
      - microcode.sv
      - useq_top.sv
  - target: simulation
    files:
      - tb_useq.sv

// ==== insn_queue.sv ====
// -----------------------------------------------
// insn_queue
// circular buffer of decoded words between the
// decoder and the microcode sequencer
// -----------------------------------------------
module insn_queue #(
    parameter int DEPTH = 4
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    input  useq_pkg::dec_word_t in_word,
    output logic                in_ready,
    output logic                head_valid,
    output useq_pkg::dec_word_t head_word,
    input  logic                take
);
    import useq_pkg::*;

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    dec_word_t       mem [DEPTH];
    logic [AW-1:0]   wr_ptr;
    logic [AW-1:0]   rd_ptr;
    logic [CW-1:0]   count;
    logic            push;

    assign in_ready   = (count != CW'(DEPTH));
    assign head_valid = (count != '0);
    assign head_word  = mem[rd_ptr];
    assign push       = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_word;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (take) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CW'(push) - CW'(take);  // push and take may coincide
        end
    end

    // the sequencer must only pop a valid head
    a_take_not_empty: assert property (@(posedge clk) disable iff (!rst_n)
        take |-> head_valid);

    a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
        count <= CW'(DEPTH));

endmodule

// ==== micro_commands.sv ====
// -----------------------------------------------
// micro_commands
// step table for the sequenced commands, gives
// the current step code and the next command
// -----------------------------------------------
`include "useq_settings.svh"

module micro_commands (
    input  logic              clk,
    input  logic              rst_n,
    input  useq_pkg::cmd_t    mc_cmd,
    input  useq_pkg::step_t   mc_step,
    input  logic              mc_operand_32bit,
    output useq_pkg::cmd_t    cmd_current,
    output useq_pkg::cmdex_t  cmdex_current,
    output useq_pkg::cmd_t    cmd_next
);
    import useq_pkg::*;

    // -----------------------------------------------
    // step counts
    // -----------------------------------------------
    // 16 and 32 bit variants are reserved, both sizes
    // currently run the same number of steps
    localparam step_t PUSHA_STEPS_16 = step_t'(`PUSHA_STEPS);
    localparam step_t PUSHA_STEPS_32 = step_t'(`PUSHA_STEPS);
    localparam step_t RETF_STEPS_16  = step_t'(`RETF_STEPS);
    localparam step_t RETF_STEPS_32  = step_t'(`RETF_STEPS);
    localparam step_t INT_STEPS_ALL  = step_t'(`INT_STEPS);

    step_t step_count;
    logic  last_step;

    always_comb begin
        case (mc_cmd)
            `CMD_pusha: begin
                step_count = mc_operand_32bit ? PUSHA_STEPS_32 : PUSHA_STEPS_16;
            end
            `CMD_retf: begin
                step_count = mc_operand_32bit ? RETF_STEPS_32 : RETF_STEPS_16;
            end
            `CMD_int: begin
                step_count = INT_STEPS_ALL;  // same for both sizes
            end
            default: begin
                step_count = step_t'(1);     // single-step command
            end
        endcase
    end

    // -----------------------------------------------
    // outputs
    // -----------------------------------------------
    assign last_step     = (mc_step >= step_count - step_t'(1));
    assign cmd_current   = mc_cmd;
    assign cmdex_current = cmdex_t'(mc_step);  // step index is the cmdex
    assign cmd_next      = last_step ? `CMD_NULL : mc_cmd;

    // a running sequence never walks past its table entry
    a_step_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        (mc_cmd != `CMD_NULL) |-> (mc_step < step_count));

endmodule

// ==== microcode.sv ====
// -----------------------------------------------
// microcode
// passes simple words to the read stage, replays
// complex words as micro-steps and starts the int
// sequence on exception entry
// -----------------------------------------------
`include "useq_settings.svh"

module microcode (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  head_valid,
    input  useq_pkg::dec_word_t   head_word,
    output logic                  take,
    input  logic                  exc_init,
    input  useq_pkg::eip_t        exc_eip,
    input  logic                  rd_busy,
    output logic                  micro_ready,
    output useq_pkg::micro_word_t micro_word
);
    import useq_pkg::*;

    localparam micro_word_t IDLE_WORD = '{
        cmd:           `CMD_NULL,
        cmdex:         '0,
        eip:           '0,
        consumed:      '0,
        operand_32bit: 1'b0,
        prefix_rep:    '0,
        prefix_seg:    `SEG_DS,
        modrm:         '0
    };

    micro_word_t mc_word;       // stored payload of the running sequence
    cmd_t        mc_cmd;
    step_t       mc_step;

    micro_word_t head_micro;
    micro_word_t exc_word;
    cmd_t        cmd_current;
    cmdex_t      cmdex_current;
    cmd_t        cmd_next;
    logic        m_overlay;
    logic        m_load;
    logic        m_advance;

    // -----------------------------------------------
    // handshake
    // -----------------------------------------------
    assign m_overlay   = (mc_cmd != `CMD_NULL);
    assign micro_ready = !rd_busy && !exc_init && (m_overlay || head_valid);
    assign take        = micro_ready && !m_overlay;       // pop only when idle
    assign m_load      = take && head_word.is_complex;
    assign m_advance   = micro_ready && m_overlay;

    micro_commands u_micro_commands (
        .clk              (clk),
        .rst_n            (rst_n),
        .mc_cmd           (mc_cmd),
        .mc_step          (mc_step),
        .mc_operand_32bit (mc_word.operand_32bit),
        .cmd_current      (cmd_current),
        .cmdex_current    (cmdex_current),
        .cmd_next         (cmd_next)
    );

    always_comb begin
        head_micro = '{
            cmd:           head_word.cmd,
            cmdex:         head_word.cmdex,
            eip:           head_word.eip,
            consumed:      head_word.consumed,
            operand_32bit: head_word.operand_32bit,
            prefix_rep:    head_word.prefix_rep,
            prefix_seg:    head_word.prefix_seg,
            modrm:         head_word.modrm
        };
        exc_word     = IDLE_WORD;
        exc_word.cmd = `CMD_int;
        exc_word.eip = exc_eip;   // consumed stays zero
    end

    // -----------------------------------------------
    // overlay registers
    // -----------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mc_cmd  <= `CMD_NULL;
            mc_step <= '0;
        end else if (exc_init) begin
            mc_cmd  <= `CMD_int;           // aborts any running sequence
            mc_step <= '0;
        end else if (m_load) begin
            mc_cmd  <= head_word.cmd;
            mc_step <= step_t'(1);         // step 0 went out in the take cycle
        end else if (m_advance) begin
            mc_cmd  <= cmd_next;
            mc_step <= (cmd_next == `CMD_NULL) ? '0 : mc_step + step_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mc_word <= IDLE_WORD;
        end else if (exc_init) begin
            mc_word <= exc_word;
        end else if (m_load) begin
            mc_word <= head_micro;
        end
    end

    // -----------------------------------------------
    // output mux
    // -----------------------------------------------
    always_comb begin
        if (m_overlay) begin
            micro_word       = mc_word;
            micro_word.cmd   = cmd_current;
            micro_word.cmdex = cmdex_current;
        end else begin
            micro_word = head_micro;     // zero-latency pass-through
        end
    end

    // a load always opens an overlay and blocks the queue
    a_load_opens_overlay: assert property (@(posedge clk) disable iff (!rst_n)
        m_load |=> (m_overlay && !take));

    // back-pressure holds the step
    a_busy_holds: assert property (@(posedge clk) disable iff (!rst_n)
        (rd_busy && !exc_init) |-> !micro_ready ##1 ($stable(mc_cmd) && $stable(mc_step)));

    a_eip_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (m_overlay && !exc_init) |=> (!m_overlay || $stable(mc_word.eip)));

endmodule

// ==== tb.f ====
+incdir+.
useq_pkg.sv
insn_queue.sv
micro_commands.sv
microcode.sv
useq_top.sv
tb_useq.sv

// ==== tb_useq.sv ====
// -------------------------------------------------
// tb_useq
// random instruction stream through the sequencer,
// checked against a queue of expected micro words
// -------------------------------------------------
`include "useq_settings.svh"

module tb_useq;
    timeunit 1ns;
    timeprecision 100ps;
    import useq_pkg::*;

    localparam int NUM_WORDS    = 40;
    localparam int FILL_WORDS   = `QUEUE_DEPTH + 2;
    localparam int WATCHDOG_CYC = (NUM_WORDS + FILL_WORDS + 2) * `PUSHA_STEPS * 4 + 500;

    typedef struct packed {
        micro_word_t w;
        logic        first;   // first delivery of a queued word
        step_t       left;    // steps of the same sequence after this one
    } exp_entry_t;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        in_valid;
    dec_word_t   in_word;
    logic        in_ready;
    logic        exc_init;
    eip_t        exc_eip;
    logic        rd_busy;
    logic        micro_ready;
    micro_word_t micro_word;

    exp_entry_t  exp_q[$];
    micro_word_t exp_front;
    logic        exp_have = 1'b0;
    int          seq_left = 0;
    int          occ = 0;
    int          acc_cnt = 0;
    logic [31:0] lfsr = 32'h6087e770;
    logic        idle_chk = 1'b0;
    logic        hold_busy = 1'b0;
    int          busy_left = 0;
    int          data_errs = 0;
    int          hs_errs = 0;
    int          queue_errs = 0;

    useq_top dut (.*);

    always #5 clk = ~clk;

    // -------------------------------------------------
    // stimulus helpers
    // -------------------------------------------------
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);  // taps 32 22 2 1
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic int step_count_of(cmd_t c);
        case (c)
            `CMD_pusha: return `PUSHA_STEPS;
            `CMD_retf:  return `RETF_STEPS;
            `CMD_int:   return `INT_STEPS;
            default:    return 1;
        endcase
    endfunction

    task automatic next_cycle();
        logic [31:0] r;
        @(negedge clk);
        idle_chk = 1'b0;
        if (hold_busy) begin
            rd_busy = 1'b1;
        end else if (busy_left > 0) begin
            rd_busy = 1'b1;
            busy_left--;
        end else begin
            rand_bits(2, r);
            rd_busy = (r[1:0] == 2'd0);     // burst start, 1 in 4
            if (rd_busy) begin
                rand_bits(2, r);
                busy_left = r[1:0];
            end
        end
    endtask

    task automatic make_word(output dec_word_t w);
        logic [31:0] r;
        rand_bits(2, r);
        case (r[1:0])
            2'd0:    w.cmd = `CMD_mov;
            2'd1:    w.cmd = `CMD_add;
            2'd2:    w.cmd = `CMD_pusha;
            default: w.cmd = `CMD_retf;
        endcase
        w.is_complex = r[1];
        rand_bits(32, r);
        w.eip = r;
        rand_bits(4, r);
        w.consumed = r[3:0];
        rand_bits(6, r);
        w.operand_32bit = r[5];
        w.prefix_rep = r[4:3];
        w.prefix_seg = r[2:0];
        rand_bits(16, r);
        w.modrm = r[15:0];
        rand_bits(4, r);
        w.cmdex = w.is_complex ? cmdex_t'(0) : r[3:0];  // sequences start at step 0
    endtask

    task automatic send_word(input dec_word_t w);
        int start;
        start = acc_cnt;
        in_valid = 1'b1;
        in_word = w;
        do next_cycle(); while (acc_cnt == start);
        in_valid = 1'b0;
    endtask

    task automatic wait_drained();
        while (exp_have || occ != 0) next_cycle();
    endtask

    // -------------------------------------------------
    // reference model, updated on the rising edge
    // -------------------------------------------------
    always @(posedge clk) begin
        exp_entry_t e;
        int n;
        if (!rst_n) begin
            exp_q.delete();
            seq_left = 0;
            occ = 0;
        end else begin
            if (micro_ready && exp_q.size() > 0) begin
                e = exp_q.pop_front();
                seq_left = e.left;
                if (e.first) occ--;        // queue head was taken
            end
            if (exc_init) begin
                while (seq_left > 0 && exp_q.size() > 0) begin
                    exp_q.delete(0);         // aborted steps
                    seq_left--;
                end
                seq_left = 0;
                for (int k = `INT_STEPS - 1; k >= 0; k--) begin
                    e = '0;
                    e.w.cmd = `CMD_int;
                    e.w.cmdex = cmdex_t'(k);
                    e.w.eip = exc_eip;
                    e.w.prefix_seg = `SEG_DS;
                    e.left = step_t'(`INT_STEPS - 1 - k);
                    exp_q.push_front(e);
                end
            end
            if (in_valid && in_ready) begin
                n = in_word.is_complex ? step_count_of(in_word.cmd) : 1;
                for (int k = 0; k < n; k++) begin
                    e.w = '{in_word.cmd, in_word.cmdex, in_word.eip, in_word.consumed,
                            in_word.operand_32bit, in_word.prefix_rep,
                            in_word.prefix_seg, in_word.modrm};
                    if (in_word.is_complex) e.w.cmdex = cmdex_t'(k);
                    e.first = (k == 0);
                    e.left = step_t'(n - 1 - k);
                    exp_q.push_back(e);
                end
                occ++;
                acc_cnt++;
            end
        end
        exp_have = (exp_q.size() != 0);
        exp_front = exp_have ? exp_q[0].w : '0;
    end

    // -------------------------------------------------
    // checks
    // -------------------------------------------------
    a_idle_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
        idle_chk |-> (!micro_ready && in_ready))
        else begin
            hs_errs++;
            $display("[ERROR] %0t: handshake not idle after reset", $time);
        end

    a_deliver: assert property (@(posedge clk) disable iff (!rst_n)
        micro_ready |-> (exp_have && micro_word == exp_front))
        else begin
            data_errs++;
            $display("[ERROR] %0t: got cmd %0d cmdex %0d eip %h, expected cmd %0d cmdex %0d eip %h",
                     $time, $sampled(micro_word.cmd), $sampled(micro_word.cmdex),
                     $sampled(micro_word.eip), $sampled(exp_front.cmd),
                     $sampled(exp_front.cmdex), $sampled(exp_front.eip));
        end

    a_busy_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        rd_busy |-> !micro_ready)
        else begin
            hs_errs++;
            $display("[ERROR] %0t: micro_ready high while rd_busy", $time);
        end

    a_ready_full: assert property (@(posedge clk) disable iff (!rst_n)
        in_ready == (occ < `QUEUE_DEPTH))
        else begin
            queue_errs++;
            $display("[ERROR] %0t: in_ready %0b with %0d queued", $time,
                     $sampled(in_ready), $sampled(occ));
        end

    // -------------------------------------------------
    // main sequence
    // -------------------------------------------------
    initial begin
        dec_word_t   w;
        logic [31:0] r;
        int          fill_start;
        rst_n = 1'b0;
        in_valid = 1'b0;
        in_word = '0;
        exc_init = 1'b0;
        exc_eip = '0;
        rd_busy = 1'b0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        idle_chk = 1'b1;                // one quiet cycle
        next_cycle();
        for (int i = 0; i < NUM_WORDS; i++) begin
            rand_bits(2, r);
            repeat (r[1:0]) next_cycle();
            if (i == 12 || i == 27) begin
                rand_bits(32, r);
                exc_eip = r;
                exc_init = 1'b1;
                next_cycle();
                exc_init = 1'b0;
            end
            make_word(w);
            send_word(w);
        end
        wait_drained();

        // fill the queue against a stalled read stage
        hold_busy = 1'b1;
        next_cycle();
        fill_start = acc_cnt;
        for (int i = 0; i < FILL_WORDS; i++) begin
            make_word(w);
            in_valid = 1'b1;
            in_word = w;
            next_cycle();
        end
        in_valid = 1'b0;
        assert (acc_cnt - fill_start == `QUEUE_DEPTH)
        else begin
            queue_errs++;
            $display("[ERROR] %0t: %0d words accepted while stalled, expected %0d",
                     $time, acc_cnt - fill_start, `QUEUE_DEPTH);
        end
        hold_busy = 1'b0;
        wait_drained();
        repeat (10) next_cycle();

        $display("errors: data %0d, handshake %0d, queue %0d", data_errs, hs_errs, queue_errs);
        if (data_errs + hs_errs + queue_errs == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYC) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYC);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== useq_pkg.sv ====
// -----------------------------------------------
// microcode sequencer types
// decoded word and micro word as seen by the
// decoder queue, the sequencer and the read stage
// -----------------------------------------------
package useq_pkg;

    typedef logic [6:0]  cmd_t;       // command code
    typedef logic [3:0]  cmdex_t;     // step code within a command
    typedef logic [31:0] eip_t;
    typedef logic [3:0]  consumed_t;  // insn length in bytes
    typedef logic [5:0]  step_t;      // sequencer step counter

    // -----------------------------------------------
    // decoded instruction, as queued
    // -----------------------------------------------
    typedef struct packed {
        cmd_t        cmd;
        cmdex_t      cmdex;
        eip_t        eip;
        consumed_t   consumed;
        logic        operand_32bit;
        logic [1:0]  prefix_rep;     // rep / repne
        logic [2:0]  prefix_seg;     // segment override
        logic [15:0] modrm;          // operand selector bits
        logic        is_complex;     // needs micro-steps
    } dec_word_t;

    // -----------------------------------------------
    // word handed to the read stage
    // -----------------------------------------------
    typedef struct packed {
        cmd_t        cmd;
        cmdex_t      cmdex;
        eip_t        eip;
        consumed_t   consumed;
        logic        operand_32bit;
        logic [1:0]  prefix_rep;
        logic [2:0]  prefix_seg;
        logic [15:0] modrm;
    } micro_word_t;

endpackage

// ==== useq_settings.svh ====
// -----------------------------------------------
// microcode sequencer settings
// command codes, step counts and queue depth
// -----------------------------------------------
`ifndef USEQ_SETTINGS_SVH
`define USEQ_SETTINGS_SVH

// command codes
`define CMD_NULL    7'd0
`define CMD_mov     7'd12
`define CMD_add     7'd9
`define CMD_pusha   7'd49
`define CMD_retf    7'd66
`define CMD_int     7'd70

// micro-steps per sequenced command
`define PUSHA_STEPS 8
`define RETF_STEPS  3
`define INT_STEPS   4

`define QUEUE_DEPTH 4
`define SEG_DS      3'd3

`endif

// ==== useq_top.sv ====
// -----------------------------------------------
// useq_top
// instruction queue feeding the microcode sequencer
// -----------------------------------------------
`include "useq_settings.svh"

module useq_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    input  useq_pkg::dec_word_t   in_word,
    output logic                  in_ready,
    input  logic                  exc_init,
    input  useq_pkg::eip_t        exc_eip,
    input  logic                  rd_busy,
    output logic                  micro_ready,
    output useq_pkg::micro_word_t micro_word
);
    import useq_pkg::*;

    logic      head_valid;
    dec_word_t head_word;
    logic      take;

    insn_queue #(
        .DEPTH (`QUEUE_DEPTH)
    ) u_insn_queue (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_word    (in_word),
        .in_ready   (in_ready),
        .head_valid (head_valid),
        .head_word  (head_word),
        .take       (take)
    );

    microcode u_microcode (
        .clk         (clk),
        .rst_n       (rst_n),
        .head_valid  (head_valid),
        .head_word   (head_word),
        .take        (take),
        .exc_init    (exc_init),
        .exc_eip     (exc_eip),
        .rd_busy     (rd_busy),
        .micro_ready (micro_ready),
        .micro_word  (micro_word)
    );

endmodule
